// File: l1_req_pkg.sv
/*
 * L1 request package
 * Cache-side request and response structs, request-type bit positions
 * and the line and address widths shared by the whole bridge
 */
package l1_req_pkg;

    localparam int ADDR_W     = 48;           // Byte address
    localparam int LINE_W     = 256;          // One L1 line
    localparam int STRB_W     = LINE_W / 8;   // One strobe per byte
    localparam int SIZE_W     = 3;
    localparam int REQ_TYPE_W = 2;

    // Request-type bit positions
    localparam int REQ_TYPE_WRITE  = 0;
    localparam int REQ_TYPE_CACHED = 1;

    // One line request from the cache
    typedef struct packed {
        logic                  valid;
        logic                  path;          // 0 data, 1 instruction
        logic [REQ_TYPE_W-1:0] req_type;
        logic [SIZE_W-1:0]     size;
        logic [ADDR_W-1:0]     addr;
        logic [STRB_W-1:0]     strob;
        logic [LINE_W-1:0]     data;
    } mem_req_t;

    // Response pulse back to the cache
    typedef struct packed {
        logic              valid;
        logic              path;
        logic [LINE_W-1:0] data;              // Read data, don't care on writes
        logic              load_fault;
        logic              store_fault;
    } mem_resp_t;

endpackage

// File: l1_axi_pkg.sv
/*
 * AXI4 package
 * Channel structs for a single-beat AXI4 master, burst, response and
 * cache encodings, and the bus state enum of the bridge
 */
package l1_axi_pkg;

    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'b00,
        AXI_BURST_INCR  = 2'b01,
        AXI_BURST_WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'b00,
        AXI_RESP_EXOKAY = 2'b01,
        AXI_RESP_SLVERR = 2'b10,
        AXI_RESP_DECERR = 2'b11   // Bit 1 set on both error codes
    } axi_resp_e;

    // AxCACHE encodings
    localparam logic [3:0] CACHE_WRBACK_ALLOC = 4'b1111;
    localparam logic [3:0] CACHE_DEVICE_NB    = 4'b0000;

    // Address channel bits, shared by AR and AW
    typedef struct packed {
        logic [l1_req_pkg::ADDR_W-1:0] addr;
        logic [l1_req_pkg::SIZE_W-1:0] size;
        axi_burst_e                    burst;
        logic [3:0]                    cache;
        logic [2:0]                    prot;  // [2] instr, [1] non-secure, [0] priv
    } axi_addr_t;

    // Master to slave
    typedef struct packed {
        logic                          ar_valid;
        axi_addr_t                     ar_bits;
        logic                          aw_valid;
        axi_addr_t                     aw_bits;
        logic                          w_valid;
        logic [l1_req_pkg::LINE_W-1:0] w_data;
        logic [l1_req_pkg::STRB_W-1:0] w_strb;
        logic                          w_last;
        logic                          r_ready;
        logic                          b_ready;
    } axi_m2s_t;

    // Slave to master
    typedef struct packed {
        logic                          ar_ready;
        logic                          aw_ready;
        logic                          w_ready;
        logic                          r_valid;
        logic [l1_req_pkg::LINE_W-1:0] r_data;
        axi_resp_e                     r_resp;
        logic                          r_last;
        logic                          b_valid;
        axi_resp_e                     b_resp;
    } axi_s2m_t;

    typedef enum logic [2:0] {
        IDLE,
        AR,
        R,
        AW,
        AW_ONLY,    // W gone, AW still waiting
        W,
        B
    } bus_state_e;

endpackage

// File: mem_req_capture.sv
/*
 * Request capture register
 * Holds the accepted cache request and forms its AXI address attributes
 */
module mem_req_capture (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    input  logic                          i_capture,
    input  l1_req_pkg::mem_req_t          i_req,
    output l1_axi_pkg::axi_addr_t         o_addr_bits,
    output logic                          o_is_write,
    output logic                          o_path,
    output logic [l1_req_pkg::STRB_W-1:0] o_wstrb,
    output logic [l1_req_pkg::LINE_W-1:0] o_wdata
);

    logic                  req_write;
    logic                  req_cached;
    logic                  is_write_q;
    l1_axi_pkg::axi_addr_t addr_bits_d;

    assign req_write  = i_req.req_type[l1_req_pkg::REQ_TYPE_WRITE];
    assign req_cached = i_req.req_type[l1_req_pkg::REQ_TYPE_CACHED];

    // AXI attributes of the incoming request
    always_comb begin
        addr_bits_d.addr  = i_req.addr;
        addr_bits_d.size  = i_req.size;
        addr_bits_d.burst = l1_axi_pkg::AXI_BURST_INCR;
        if (req_cached) begin
            addr_bits_d.cache = l1_axi_pkg::CACHE_WRBACK_ALLOC;
        end else begin
            addr_bits_d.cache = l1_axi_pkg::CACHE_DEVICE_NB;
        end
        addr_bits_d.prot  = {i_req.path, 2'b00};     // Unprivileged, secure
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            is_write_q <= 1'b0;
            o_path     <= 1'b0;
        end else if (i_capture) begin
            is_write_q <= req_write;
            o_path     <= i_req.path;
        end
    end

    // Line payload, zeroed for reads
    always_ff @(posedge i_clk) begin
        if (i_capture) begin
            o_addr_bits <= addr_bits_d;
            if (req_write) begin
                o_wstrb <= i_req.strob;
                o_wdata <= i_req.data;
            end else begin
                o_wstrb <= '0;
                o_wdata <= '0;
            end
        end
    end

    // In the capture cycle the FSM already needs the direction to pick AR or AW
    assign o_is_write = i_capture ? req_write : is_write_q;

    // Capture strobe comes from the FSM, valid from the cache
    a_capture_valid: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        i_capture |-> i_req.valid
    ) else $error("capture without a valid request");

endmodule

// File: axi_bus_fsm.sv
/*
 * AXI4 bus sequencer
 * Runs one single-beat read or write per request on the AXI channels
 * and returns the response pulse to the cache
 */
module axi_bus_fsm (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    input  logic                          i_req_valid,
    output logic                          o_req_ready,
    output logic                          o_capture,
    input  l1_axi_pkg::axi_addr_t         i_addr_bits,
    input  logic                          i_is_write,
    input  logic                          i_path,
    input  logic [l1_req_pkg::STRB_W-1:0] i_wstrb,
    input  logic [l1_req_pkg::LINE_W-1:0] i_wdata,
    input  l1_axi_pkg::axi_s2m_t          i_axi,
    output l1_axi_pkg::axi_m2s_t          o_axi,
    output l1_req_pkg::mem_resp_t         o_resp
);

    l1_axi_pkg::bus_state_e state;
    l1_axi_pkg::bus_state_e state_nxt;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= l1_axi_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Next state
    always_comb begin
        state_nxt = state;
        unique case (state)
            l1_axi_pkg::IDLE: begin
                if (i_req_valid) begin
                    if (i_is_write) begin
                        state_nxt = l1_axi_pkg::AW;
                    end else begin
                        state_nxt = l1_axi_pkg::AR;
                    end
                end
            end
            l1_axi_pkg::AR: begin
                if (i_axi.ar_ready) begin
                    state_nxt = l1_axi_pkg::R;
                end
            end
            l1_axi_pkg::R: begin
                if (i_axi.r_valid && i_axi.r_last) begin
                    state_nxt = l1_axi_pkg::IDLE;
                end
            end
            l1_axi_pkg::AW: begin
                // Address and data offered together, either may go first
                if (i_axi.aw_ready && i_axi.w_ready) begin
                    state_nxt = l1_axi_pkg::B;
                end else if (i_axi.aw_ready) begin
                    state_nxt = l1_axi_pkg::W;
                end else if (i_axi.w_ready) begin
                    state_nxt = l1_axi_pkg::AW_ONLY;
                end
            end
            l1_axi_pkg::AW_ONLY: begin
                if (i_axi.aw_ready) begin
                    state_nxt = l1_axi_pkg::B;
                end
            end
            l1_axi_pkg::W: begin
                if (i_axi.w_ready) begin
                    state_nxt = l1_axi_pkg::B;
                end
            end
            l1_axi_pkg::B: begin
                if (i_axi.b_valid) begin
                    state_nxt = l1_axi_pkg::IDLE;
                end
            end
            default: begin
                state_nxt = l1_axi_pkg::IDLE;
            end
        endcase
    end

    assign o_req_ready = (state == l1_axi_pkg::IDLE);
    assign o_capture   = (state == l1_axi_pkg::IDLE) && i_req_valid;

    // Channel outputs, bits held steady and qualified by valid
    always_comb begin
        o_axi         = '0;
        o_axi.ar_bits = i_addr_bits;
        o_axi.aw_bits = i_addr_bits;
        o_axi.w_data  = i_wdata;
        o_axi.w_strb  = i_wstrb;
        o_axi.w_last  = 1'b1;                      // Always a single beat

        o_axi.ar_valid = (state == l1_axi_pkg::AR);
        o_axi.aw_valid = (state == l1_axi_pkg::AW) || (state == l1_axi_pkg::AW_ONLY);
        o_axi.w_valid  = (state == l1_axi_pkg::AW) || (state == l1_axi_pkg::W);
        o_axi.r_ready  = (state == l1_axi_pkg::R);
        o_axi.b_ready  = (state == l1_axi_pkg::B);
    end

    // Response pulse, taken straight from R or B
    always_comb begin
        o_resp             = '0;
        o_resp.path        = i_path;
        o_resp.data        = i_axi.r_data;
        if (state == l1_axi_pkg::R) begin
            o_resp.valid      = i_axi.r_valid && i_axi.r_last;
            o_resp.load_fault = i_axi.r_resp[1];   // SLVERR or DECERR
        end else if (state == l1_axi_pkg::B) begin
            o_resp.valid       = i_axi.b_valid;
            o_resp.store_fault = i_axi.b_resp[1];
        end
    end

    // Single-beat reads only, so the slave must mark every beat last
    a_r_last: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (state == l1_axi_pkg::R && i_axi.r_valid) |-> i_axi.r_last
    ) else $error("r_valid without r_last");

    a_ar_stable: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (o_axi.ar_valid && !i_axi.ar_ready) |=> o_axi.ar_valid && $stable(o_axi.ar_bits)
    ) else $error("AR dropped or changed before ar_ready");

endmodule

// File: l1_axi_bridge.sv
/*
 * L1 to AXI4 bridge
 * Turns cache line requests into single-beat AXI4 transactions
 */
module l1_axi_bridge (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  l1_req_pkg::mem_req_t  i_req,
    output logic                  o_req_ready,
    output l1_req_pkg::mem_resp_t o_resp,
    output l1_axi_pkg::axi_m2s_t  o_axi,
    input  l1_axi_pkg::axi_s2m_t  i_axi
);

    logic                          capture;
    l1_axi_pkg::axi_addr_t         addr_bits;
    logic                          is_write;
    logic                          path;
    logic [l1_req_pkg::STRB_W-1:0] wstrb;
    logic [l1_req_pkg::LINE_W-1:0] wdata;

    mem_req_capture capture_i (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_capture   (capture),
        .i_req       (i_req),
        .o_addr_bits (addr_bits),
        .o_is_write  (is_write),
        .o_path      (path),
        .o_wstrb     (wstrb),
        .o_wdata     (wdata)
    );

    axi_bus_fsm fsm_i (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_req_valid (i_req.valid),
        .o_req_ready (o_req_ready),
        .o_capture   (capture),
        .i_addr_bits (addr_bits),
        .i_is_write  (is_write),
        .i_path      (path),
        .i_wstrb     (wstrb),
        .i_wdata     (wdata),
        .i_axi       (i_axi),
        .o_axi       (o_axi),
        .o_resp      (o_resp)
    );

endmodule

// File: tb_axi_mem.sv
/*
 * AXI4 slave model for the bridge testbench
 * Single-beat reads and writes on a 16-line memory with per-cycle stalls,
 * SLVERR for addresses with bit 47 set
 */
module tb_axi_mem (
    input  logic                 i_clk,
    input  logic                 i_nrst,
    input  logic [4:0]           i_stall,     // ar, aw, w, r, b from bit 0 up
    input  l1_axi_pkg::axi_m2s_t i_axi,
    output l1_axi_pkg::axi_s2m_t o_axi
);

    logic [l1_req_pkg::LINE_W-1:0] mem [16];
    logic [l1_req_pkg::LINE_W-1:0] r_data_q;
    logic                          r_pend;
    logic                          r_valid_q;
    logic                          r_err_q;
    logic                          aw_got;
    logic                          w_got;
    logic [l1_req_pkg::ADDR_W-1:0] aw_addr_q;
    logic [l1_req_pkg::STRB_W-1:0] w_strb_q;
    logic [l1_req_pkg::LINE_W-1:0] w_data_q;
    logic                          b_pend;
    logic                          b_valid_q;
    logic                          b_err_q;
    logic                          aw_hs;
    logic                          w_hs;
    logic [l1_req_pkg::ADDR_W-1:0] wr_addr;
    logic [l1_req_pkg::STRB_W-1:0] wr_strb;
    logic [l1_req_pkg::LINE_W-1:0] wr_data;

    // Bit 47 picks the error half, bits 7:5 the line
    function automatic logic [3:0] line_idx(input logic [l1_req_pkg::ADDR_W-1:0] a);
        return {a[47], a[7:5]};
    endfunction

    function automatic logic [l1_req_pkg::LINE_W-1:0] fill_line(input logic [3:0] idx);
        logic [l1_req_pkg::LINE_W-1:0] line;
        for (int w = 0; w < 8; w++) begin
            line[32*w +: 32] = {16'hC0DE, 4'h0, idx, 5'h00, 3'(w)};
        end
        return line;
    endfunction

    always_comb begin
        o_axi          = '0;
        o_axi.ar_ready = !i_stall[0];
        o_axi.aw_ready = !i_stall[1];
        o_axi.w_ready  = !i_stall[2];
        o_axi.r_valid  = r_valid_q;
        o_axi.r_data   = r_data_q;
        o_axi.r_resp   = r_err_q ? l1_axi_pkg::AXI_RESP_SLVERR : l1_axi_pkg::AXI_RESP_OKAY;
        o_axi.r_last   = 1'b1;
        o_axi.b_valid  = b_valid_q;
        o_axi.b_resp   = b_err_q ? l1_axi_pkg::AXI_RESP_SLVERR : l1_axi_pkg::AXI_RESP_OKAY;
    end

    assign aw_hs   = i_axi.aw_valid && !i_stall[1];
    assign w_hs    = i_axi.w_valid && !i_stall[2];
    assign wr_addr = aw_got ? aw_addr_q : i_axi.aw_bits.addr;
    assign wr_strb = w_got ? w_strb_q : i_axi.w_strb;
    assign wr_data = w_got ? w_data_q : i_axi.w_data;

    always @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < 16; i++) begin
                mem[i] <= fill_line(4'(i));
            end
            r_data_q  <= '0;
            r_pend    <= 1'b0;
            r_valid_q <= 1'b0;
            r_err_q   <= 1'b0;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
            aw_addr_q <= '0;
            w_strb_q  <= '0;
            w_data_q  <= '0;
            b_pend    <= 1'b0;
            b_valid_q <= 1'b0;
            b_err_q   <= 1'b0;
        end else begin
            if (i_axi.ar_valid && !i_stall[0]) begin
                r_data_q <= mem[line_idx(i_axi.ar_bits.addr)];   // Data returned even on error
                r_err_q  <= i_axi.ar_bits.addr[47];
                r_pend   <= 1'b1;
            end
            if (r_valid_q && i_axi.r_ready) begin
                r_valid_q <= 1'b0;
            end else if (r_pend && !i_stall[3]) begin
                r_valid_q <= 1'b1;
                r_pend    <= 1'b0;
            end

            if (aw_hs) begin
                aw_got    <= 1'b1;
                aw_addr_q <= i_axi.aw_bits.addr;
            end
            if (w_hs) begin
                w_got    <= 1'b1;
                w_strb_q <= i_axi.w_strb;
                w_data_q <= i_axi.w_data;
            end
            // Write lands once both address and data are in, in either order
            if ((aw_got || aw_hs) && (w_got || w_hs)) begin
                if (!wr_addr[47]) begin
                    for (int b = 0; b < l1_req_pkg::STRB_W; b++) begin
                        if (wr_strb[b]) begin
                            mem[line_idx(wr_addr)][8*b +: 8] <= wr_data[8*b +: 8];
                        end
                    end
                end
                aw_got  <= 1'b0;
                w_got   <= 1'b0;
                b_pend  <= 1'b1;
                b_err_q <= wr_addr[47];
            end
            if (b_valid_q && i_axi.b_ready) begin
                b_valid_q <= 1'b0;
            end else if (b_pend && !i_stall[4]) begin
                b_valid_q <= 1'b1;
                b_pend    <= 1'b0;
            end
        end
    end

endmodule

// File: tb_top.sv
/*
 * Testbench for the L1 to AXI4 bridge
 * Random line requests against a stalling AXI slave model,
 * checked against a mirror memory and a queue of expected responses
 */
module tb_top;

    localparam int NUM_REQ   = 300;
    localparam int MAX_CYCLE = NUM_REQ * 40;

    logic                          clk;
    logic                          nrst;
    l1_req_pkg::mem_req_t          req;
    logic                          req_ready;
    l1_req_pkg::mem_resp_t         resp;
    l1_axi_pkg::axi_m2s_t          axi_m2s;
    l1_axi_pkg::axi_s2m_t          axi_s2m;
    logic [4:0]                    stall;
    logic [31:0]                   req_rng;
    logic [31:0]                   stall_rng;
    logic [l1_req_pkg::LINE_W-1:0] mirror [16];
    l1_req_pkg::mem_resp_t         exp_q [$];
    l1_axi_pkg::axi_addr_t         exp_addr;
    logic                          exp_write;
    logic                          in_flight;
    int                            cycles;
    int                            n_resp;
    int                            val_errs;
    int                            proto_errs;

    l1_axi_bridge dut_i (
        .i_clk       (clk),
        .i_nrst      (nrst),
        .i_req       (req),
        .o_req_ready (req_ready),
        .o_resp      (resp),
        .o_axi       (axi_m2s),
        .i_axi       (axi_s2m)
    );

    tb_axi_mem mem_i (
        .i_clk   (clk),
        .i_nrst  (nrst),
        .i_stall (stall),
        .i_axi   (axi_m2s),
        .o_axi   (axi_s2m)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_req_rand();
        req_rng = xorshift32(req_rng);
        return req_rng;
    endfunction

    function automatic logic [3:0] line_idx(input logic [l1_req_pkg::ADDR_W-1:0] a);
        return {a[47], a[7:5]};
    endfunction

    // Same start pattern as the slave memory after reset
    function automatic logic [l1_req_pkg::LINE_W-1:0] fill_line(input logic [3:0] idx);
        logic [l1_req_pkg::LINE_W-1:0] line;
        for (int w = 0; w < 8; w++) begin
            line[32*w +: 32] = {16'hC0DE, 4'h0, idx, 5'h00, 3'(w)};
        end
        return line;
    endfunction

    task automatic check_resp(input string name, input l1_req_pkg::mem_resp_t exp,
                              input l1_req_pkg::mem_resp_t act, input logic with_data);
        if (act.path !== exp.path || (with_data && act.data !== exp.data)) begin
            val_errs++;
            $display("ERROR %s: expected path %0b data %h, actual path %0b data %h",
                     name, exp.path, exp.data, act.path, act.data);
        end
    endtask

    task automatic check_addr(input string name, input l1_axi_pkg::axi_addr_t exp,
                              input l1_axi_pkg::axi_addr_t act);
        if (act !== exp) begin
            val_errs++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_fault(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            val_errs++;
            $display("ERROR %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    task automatic check_reset_outputs();
        if (req_ready !== 1'b1 || axi_m2s.ar_valid !== 1'b0 || axi_m2s.aw_valid !== 1'b0 ||
            axi_m2s.w_valid !== 1'b0 || axi_m2s.r_ready !== 1'b0 ||
            axi_m2s.b_ready !== 1'b0) begin
            proto_errs++;
            $display("Bridge outputs not in their reset values during reset");
        end
    endtask

    // Expected response and AXI bits of the request being accepted
    task automatic accept_req();
        l1_req_pkg::mem_resp_t exp;
        logic [3:0]            idx;
        logic                  fault;
        idx       = line_idx(req.addr);
        fault     = req.addr[47];
        exp       = '0;
        exp.valid = 1'b1;
        exp.path  = req.path;
        exp_write = req.req_type[l1_req_pkg::REQ_TYPE_WRITE];
        if (exp_write) begin
            exp.store_fault = fault;
            for (int b = 0; b < l1_req_pkg::STRB_W; b++) begin
                if (!fault && req.strob[b]) begin
                    mirror[idx][8*b +: 8] = req.data[8*b +: 8];
                end
            end
        end else begin
            exp.data       = mirror[idx];
            exp.load_fault = fault;
        end
        exp_addr.addr  = req.addr;
        exp_addr.size  = req.size;
        exp_addr.burst = l1_axi_pkg::AXI_BURST_INCR;
        exp_addr.cache = req.req_type[l1_req_pkg::REQ_TYPE_CACHED] ?
                         l1_axi_pkg::CACHE_WRBACK_ALLOC : l1_axi_pkg::CACHE_DEVICE_NB;
        exp_addr.prot  = {req.path, 2'b00};
        exp_q.push_back(exp);
        in_flight = 1'b1;
    endtask

    // Sampled at the falling edge, where every handshake of the next rise is settled
    task automatic check_cycle();
        l1_req_pkg::mem_resp_t exp;
        if (in_flight && req_ready) begin
            proto_errs++;
            $display("Request port ready while a transaction is in flight");
        end
        if (axi_m2s.ar_valid && axi_s2m.ar_ready) begin
            if (!in_flight || exp_write) begin
                proto_errs++;
                $display("Read address issued with no read in flight");
            end else begin
                check_addr("ar_bits", exp_addr, axi_m2s.ar_bits);
            end
        end
        if (axi_m2s.aw_valid && axi_s2m.aw_ready) begin
            if (!in_flight || !exp_write) begin
                proto_errs++;
                $display("Write address issued with no write in flight");
            end else begin
                check_addr("aw_bits", exp_addr, axi_m2s.aw_bits);
            end
        end
        if (axi_m2s.w_valid && axi_m2s.w_last !== 1'b1) begin
            proto_errs++;
            $display("Write data offered without w_last");
        end
        if (axi_s2m.r_valid && axi_m2s.r_ready !== 1'b1) begin
            proto_errs++;
            $display("Read data offered while the bridge is not ready for it");
        end
        if (axi_s2m.b_valid && axi_m2s.b_ready !== 1'b1) begin
            proto_errs++;
            $display("Write response offered while the bridge is not ready for it");
        end
        if (resp.valid) begin
            if (exp_q.size() == 0) begin
                proto_errs++;
                $display("Response pulse with no request outstanding");
            end else begin
                exp = exp_q.pop_front();
                n_resp++;
                check_resp("resp", exp, resp, !exp_write);
                check_fault("load_fault", exp.load_fault, resp.load_fault);
                check_fault("store_fault", exp.store_fault, resp.store_fault);
            end
            in_flight = 1'b0;
        end
        if (req.valid && req_ready) begin
            accept_req();
        end
    endtask

    always @(negedge clk) begin
        if (nrst) begin
            cycles++;
            if (cycles > MAX_CYCLE) begin
                $display("Timeout after %0d cycles with %0d of %0d responses seen",
                         cycles, n_resp, NUM_REQ);
                $display("TEST FAILED");
                $finish;
            end else begin
                check_cycle();
            end
        end
    end

    // Each slave channel stalls about one cycle in four
    always @(posedge clk) begin
        #1;
        stall_rng = xorshift32(stall_rng);
        for (int s = 0; s < 5; s++) begin
            stall[s] = (stall_rng[2*s +: 2] == 2'b00);
        end
    end

    task automatic send_req();
        logic [31:0] r;
        r              = next_req_rand();
        req            = '0;
        req.valid      = 1'b1;
        req.path       = r[5];
        req.req_type   = r[4:3];
        req.size       = r[2:0];
        req.addr[47]   = r[9];             // Upper half of the lines answers SLVERR
        req.addr[7:5]  = r[8:6];
        req.strob      = next_req_rand();
        for (int w = 0; w < 8; w++) begin
            req.data[32*w +: 32] = next_req_rand();
        end
        do begin
            @(negedge clk);
        end while (!req_ready);
        @(posedge clk);
        #1;
        req.valid = 1'b0;
    endtask

    initial begin
        clk        = 1'b0;
        nrst       = 1'b0;
        req        = '0;
        stall      = '0;
        req_rng    = 32'd23;
        stall_rng  = xorshift32(32'd23) ^ 32'h9E37_79B9;
        exp_addr   = '0;
        exp_write  = 1'b0;
        in_flight  = 1'b0;
        cycles     = 0;
        n_resp     = 0;
        val_errs   = 0;
        proto_errs = 0;
        for (int i = 0; i < 16; i++) begin
            mirror[i] = fill_line(4'(i));
        end

        repeat (2) @(posedge clk);
        #1;
        check_reset_outputs();
        nrst = 1'b1;

        for (int n = 0; n < NUM_REQ; n++) begin
            send_req();
            if (next_req_rand() % 4 == 0) begin     // Occasional idle cycle
                @(posedge clk);
                #1;
            end
        end
        while (in_flight) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        if (exp_q.size() != 0 || n_resp != NUM_REQ) begin
            proto_errs++;
            $display("Run ended with %0d of %0d responses received", n_resp, NUM_REQ);
        end
        $display("Summary: %0d responses, %0d value errors, %0d protocol errors",
                 n_resp, val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
l1_req_pkg.sv
l1_axi_pkg.sv
mem_req_capture.sv
axi_bus_fsm.sv
l1_axi_bridge.sv
tb_axi_mem.sv
tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the L1 to AXI4 bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_top -f verilog.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
